/* run_sim.sh */
#!/bin/sh
verilator --binary --assert --top-module uc_tb -f sources.f -o uc_sim || exit 1
./obj_dir/uc_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

/* source/alu_control.sv */
`default_nettype none

module alu_control (
    input  wire uc_pkg::state_t     state,
    input  wire uc_pkg::opcode_t    opcode,
    input  wire                     ind_carry,
    output uc_pkg::alu_op_t         alu_opcode,
    output logic                    alu_carry
);

    import uc_pkg::*;

    always_comb begin
        alu_opcode = alu_adc;
        alu_carry  = 1'b0;
        case (state)
            addr_sum_2: alu_opcode = alu_adc;           // base + index
            load_src_mem,
            load_dst_mem,
            store_reg,
            store_mem:  alu_opcode = alu_or;            // pass one temp through
            inc_cp_1: begin
                alu_opcode = alu_adc;
                alu_carry  = 1'b1;                      // cp + 1
            end

            exec_1op: begin
                if (opcode[3]) begin
                    case (opcode[4:6])
                        3'b000: begin                   // inc
                            alu_opcode = alu_adc;
                            alu_carry  = 1'b1;
                        end
                        3'b001: begin                   // dec
                            alu_opcode = alu_sbb1;
                            alu_carry  = 1'b1;
                        end
                        3'b010: alu_opcode = alu_sbb2;  // neg, 0 - a
                        3'b011: alu_opcode = alu_not;
                        3'b100: alu_opcode = alu_shl;
                        3'b101: alu_opcode = alu_shr;
                        3'b110: alu_opcode = alu_sar;
                        default: ;
                    endcase
                end else begin
                    alu_opcode = alu_or;                // mov, jmp
                end
            end

            exec_2op: begin
                case (opcode[4:6])
                    3'b000: alu_opcode = alu_adc;       // add
                    3'b001: begin                       // adc
                        alu_opcode = alu_adc;
                        alu_carry  = ind_carry;
                    end
                    3'b010: alu_opcode = alu_sbb1;      // sub, cmp
                    3'b011: begin                       // sbb
                        alu_opcode = alu_sbb1;
                        alu_carry  = ind_carry;
                    end
                    3'b100: alu_opcode = alu_and;       // and, test
                    3'b101: alu_opcode = alu_or;
                    3'b110: alu_opcode = alu_xor;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/bus_control.sv */
`default_nettype none

`include "uc_consts.svh"

module bus_control (
    input  wire uc_pkg::state_t     state,
    input  wire                     decoded_d,
    input  wire uc_pkg::opcode_t    opcode,
    input  wire uc_pkg::reg_addr_t  rg,
    input  wire uc_pkg::reg_addr_t  rm,
    input  wire uc_pkg::word_t      ind,
    output uc_pkg::reg_addr_t       regs_addr,
    output logic                    regs_oe,
    output logic                    regs_we,
    output logic                    alu_oe,
    output logic                    alu_carry,
    output uc_pkg::alu_op_t         alu_opcode,
    output logic                    ram_oe,
    output logic                    ram_we,
    output logic                    cp_oe,
    output logic                    cp_we,
    output logic                    ind_sel,        // ind input: 0 bus, 1 alu flags
    output logic                    ind_oe,
    output logic                    ind_we,
    output logic                    am_oe,
    output logic                    am_we,
    output logic                    t1_oe,
    output logic                    t1_we,
    output logic                    t2_oe,
    output logic                    t2_we,
    output logic                    ri_oe,
    output logic                    ri_we
);

    import uc_pkg::*;

    alu_control alu_control_i (
        .state      (state),
        .opcode     (opcode),
        .ind_carry  (ind[0]),
        .alu_opcode (alu_opcode),
        .alu_carry  (alu_carry)
    );

    always_comb begin
        regs_addr = '0;
        regs_oe   = 1'b0;
        regs_we   = 1'b0;
        alu_oe    = 1'b0;
        ram_oe    = 1'b0;
        ram_we    = 1'b0;
        cp_oe     = 1'b0;
        cp_we     = 1'b0;
        ind_sel   = 1'b0;
        ind_oe    = 1'b0;
        ind_we    = 1'b0;
        am_oe     = 1'b0;
        am_we     = 1'b0;
        t1_oe     = 1'b0;
        t1_we     = 1'b0;
        t2_oe     = 1'b0;
        t2_we     = 1'b0;
        ri_oe     = 1'b0;
        ri_we     = 1'b0;

        case (state)
            //////////////////// fetch
            fetch: begin
                cp_oe = 1'b1;
                am_we = 1'b1;
            end
            fetch_1: am_oe = 1'b1;
            fetch_2: begin
                ram_oe = 1'b1;
                ri_we  = 1'b1;
            end

            //////////////////// address
            addr_sum: begin
                regs_addr = rm[1] ? `UC_REG_BB : `UC_REG_BA;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            addr_sum_1: begin
                regs_addr = rm[2] ? `UC_REG_XB : `UC_REG_XA;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            addr_sum_2: begin
                t1_oe  = 1'b1;
                t2_oe  = 1'b1;
                alu_oe = 1'b1;
                t2_we  = decoded_d;                 // address goes to the memory operand's temp
                t1_we  = !decoded_d;
            end
            addr_reg: begin
                regs_addr = rm;
                regs_oe   = 1'b1;
                t2_we     = decoded_d;
                t1_we     = !decoded_d;
            end

            //////////////////// operands
            load_src_reg: begin
                regs_addr = decoded_d ? rm : rg;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            load_src_mem: begin
                t2_oe  = 1'b1;
                alu_oe = 1'b1;
                am_we  = 1'b1;
            end
            load_dst_reg: begin
                regs_addr = decoded_d ? rg : rm;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            load_dst_mem: begin
                t1_oe  = 1'b1;
                alu_oe = 1'b1;
                am_we  = 1'b1;
            end
            load_src_mem_1,
            load_dst_mem_1: am_oe = 1'b1;
            load_src_mem_2: begin
                ram_oe = 1'b1;
                t2_we  = 1'b1;
            end
            load_dst_mem_2: begin
                ram_oe = 1'b1;
                t1_we  = 1'b1;
            end

            //////////////////// execute
            exec_1op: begin
                alu_oe = 1'b1;
                t1_we  = 1'b1;
                if (opcode[3]) begin
                    t1_oe   = 1'b1;
                    ind_sel = 1'b1;
                    ind_we  = 1'b1;
                end else if (opcode[4:6] == 3'b000) begin
                    t2_oe = 1'b1;                   // mov takes the source
                end else if (opcode[4:6] == 3'b101) begin
                    t1_oe = 1'b1;
                    cp_we = 1'b1;                   // jmp loads cp
                end
            end
            exec_2op: begin
                t1_oe   = 1'b1;
                t2_oe   = 1'b1;
                alu_oe  = 1'b1;
                t1_we   = 1'b1;
                ind_sel = 1'b1;
                ind_we  = 1'b1;
            end

            //////////////////// store and cp
            store_reg: begin
                t1_oe     = 1'b1;
                alu_oe    = 1'b1;
                regs_addr = decoded_d ? rg : rm;
                regs_we   = 1'b1;
            end
            store_mem: begin
                t1_oe  = 1'b1;
                alu_oe = 1'b1;
                am_oe  = 1'b1;
                ram_we = 1'b1;
            end
            inc_cp: begin
                cp_oe = 1'b1;
                t1_we = 1'b1;
            end
            inc_cp_1: begin
                t1_oe  = 1'b1;
                alu_oe = 1'b1;
                cp_we  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
`default_nettype none

`include "uc_consts.svh"

module instr_decoder (
    input  wire uc_pkg::word_t      ri,
    output uc_pkg::opcode_t         opcode,
    output uc_pkg::mod_t            mod,
    output uc_pkg::reg_addr_t       rg,
    output uc_pkg::reg_addr_t       rm,
    output logic                    d_plan,
    output uc_pkg::state_t          src_plan,
    output uc_pkg::state_t          dst_plan,
    output uc_pkg::state_t          exec_plan,
    output uc_pkg::state_t          store_plan,
    output uc_pkg::state_t          entry_state
);

    import uc_pkg::*;

    logic [0:`UC_WORD_WIDTH-1] ri_f;                // ri with bit 0 on the left
    logic                      d;
    logic                      two_op;
    logic                      one_op;
    logic                      is_jmp;
    logic                      reg_mode;
    logic                      mem_dst;
    logic                      mem_src;

    assign ri_f   = {<<{ri}};
    assign opcode = ri_f[0:6];
    assign d      = ri_f[7];
    assign mod    = ri_f[8:9];
    assign rg     = ri_f[10:12];
    assign rm     = ri_f[13:15];

    assign two_op   = opcode[1];
    assign one_op   = !opcode[1] && opcode[3];
    assign is_jmp   = !two_op && !one_op && (opcode[4:6] == 3'b101);
    assign reg_mode = (mod == 2'b11);               // mod 01 falls in with 00
    assign d_plan   = one_op ? 1'b0 : d;
    assign mem_dst  = !reg_mode && !d_plan;
    assign mem_src  = !reg_mode && (d_plan || one_op);  // inc [m] reads and writes m

    always_comb begin
        src_plan   = mem_src ? load_src_mem : load_src_reg;
        dst_plan   = mem_dst ? load_dst_mem : load_dst_reg;
        exec_plan  = two_op ? exec_2op : exec_1op;
        store_plan = mem_dst ? store_mem : store_reg;
        if (is_jmp) begin
            store_plan = fetch;                     // jump target already in cp
            if (!reg_mode)
                src_plan = exec_1op;                // address is the target
        end else if (two_op && !opcode[3]) begin
            store_plan = inc_cp;                    // cmp, test only set flags
        end

        if (reg_mode)
            entry_state = src_plan;
        else if (rm[0])
            entry_state = addr_reg;
        else
            entry_state = addr_sum;
    end

endmodule

`default_nettype wire

/* source/uc.sv */
`default_nettype none

module uc (
    input  wire                     clk,
    input  wire                     rst,
    input  wire uc_pkg::word_t      ri,
    input  wire uc_pkg::word_t      ind,
    output uc_pkg::reg_addr_t       regs_addr,
    output logic                    regs_oe,
    output logic                    regs_we,
    output logic                    alu_oe,
    output logic                    alu_carry,
    output uc_pkg::alu_op_t         alu_opcode,
    output logic                    ram_oe,
    output logic                    ram_we,
    output logic                    cp_oe,
    output logic                    cp_we,
    output logic                    ind_sel,
    output logic                    ind_oe,
    output logic                    ind_we,
    output logic                    am_oe,
    output logic                    am_we,
    output logic                    t1_oe,
    output logic                    t1_we,
    output logic                    t2_oe,
    output logic                    t2_we,
    output logic                    ri_oe,
    output logic                    ri_we,
    output uc_pkg::state_t          disp_state      // current state code
);

    import uc_pkg::*;

    opcode_t   opcode;                              // live fields, ri is held
    reg_addr_t rg;
    reg_addr_t rm;
    logic      d_plan;
    logic      decoded_d;
    state_t    src_plan;
    state_t    dst_plan;
    state_t    exec_plan;
    state_t    store_plan;
    state_t    entry_state;

    instr_decoder instr_decoder_i (
        .mod (),
        .*
    );

    uc_sequencer uc_sequencer_i (
        .state (disp_state),
        .*
    );

    bus_control bus_control_i (
        .state (disp_state),
        .*
    );

endmodule

`default_nettype wire

/* source/uc_consts.svh */
`ifndef UC_CONSTS_SVH
`define UC_CONSTS_SVH

`define UC_WORD_WIDTH       16              // instruction and flag words
`define UC_STATE_WIDTH      16              // state code on disp_state

//////////////////// base and index registers
`define UC_REG_XA           3'd4
`define UC_REG_XB           3'd5
`define UC_REG_BA           3'd6
`define UC_REG_BB           3'd7

//////////////////// state base codes
`define UC_ST_RESET         16'h00
`define UC_ST_FETCH         16'h10          // three cycles
`define UC_ST_DECODE        16'h20
`define UC_ST_ADDR_SUM      16'h30          // [b + x], three cycles
`define UC_ST_ADDR_REG      16'h34          // [rm]
`define UC_ST_LOAD_SRC_REG  16'h40
`define UC_ST_LOAD_SRC_MEM  16'h44
`define UC_ST_LOAD_DST_REG  16'h50
`define UC_ST_LOAD_DST_MEM  16'h54
`define UC_ST_EXEC_1OP      16'h60
`define UC_ST_EXEC_2OP      16'h64
`define UC_ST_STORE_REG     16'h70
`define UC_ST_STORE_MEM     16'h74
`define UC_ST_INC_CP        16'h80

`endif

/* source/uc_pkg.sv */
`default_nettype none

`include "uc_consts.svh"

package uc_pkg;

    typedef logic [`UC_WORD_WIDTH-1:0] word_t;     // ri and ind
    typedef logic [0:6] opcode_t;                  // bit 0 is the msb, as in ri
    typedef logic [0:1] mod_t;
    typedef logic [0:2] reg_addr_t;

    typedef enum logic [3:0] {
        alu_adc  = 4'd0,
        alu_sbb1 = 4'd1,                            // a - b - c
        alu_sbb2 = 4'd2,                            // b - a - c
        alu_not  = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_shl  = 4'd7,
        alu_shr  = 4'd8,
        alu_sar  = 4'd9
    } alu_op_t;

    typedef enum logic [`UC_STATE_WIDTH-1:0] {
        reset          = `UC_ST_RESET,
        fetch          = `UC_ST_FETCH,
        fetch_1        = `UC_ST_FETCH + 16'd1,
        fetch_2        = `UC_ST_FETCH + 16'd2,
        decode         = `UC_ST_DECODE,
        addr_sum       = `UC_ST_ADDR_SUM,
        addr_sum_1     = `UC_ST_ADDR_SUM + 16'd1,
        addr_sum_2     = `UC_ST_ADDR_SUM + 16'd2,
        addr_reg       = `UC_ST_ADDR_REG,
        load_src_reg   = `UC_ST_LOAD_SRC_REG,
        load_src_mem   = `UC_ST_LOAD_SRC_MEM,
        load_src_mem_1 = `UC_ST_LOAD_SRC_MEM + 16'd1,
        load_src_mem_2 = `UC_ST_LOAD_SRC_MEM + 16'd2,
        load_dst_reg   = `UC_ST_LOAD_DST_REG,
        load_dst_mem   = `UC_ST_LOAD_DST_MEM,
        load_dst_mem_1 = `UC_ST_LOAD_DST_MEM + 16'd1,
        load_dst_mem_2 = `UC_ST_LOAD_DST_MEM + 16'd2,
        exec_1op       = `UC_ST_EXEC_1OP,
        exec_2op       = `UC_ST_EXEC_2OP,
        store_reg      = `UC_ST_STORE_REG,
        store_mem      = `UC_ST_STORE_MEM,
        store_mem_1    = `UC_ST_STORE_MEM + 16'd1,
        inc_cp         = `UC_ST_INC_CP,
        inc_cp_1       = `UC_ST_INC_CP + 16'd1
    } state_t;

endpackage

`default_nettype wire

/* source/uc_sequencer.sv */
`default_nettype none

module uc_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     d_plan,
    input  wire uc_pkg::state_t     src_plan,
    input  wire uc_pkg::state_t     dst_plan,
    input  wire uc_pkg::state_t     exec_plan,
    input  wire uc_pkg::state_t     store_plan,
    input  wire uc_pkg::state_t     entry_state,
    output uc_pkg::state_t          state,
    output logic                    decoded_d
);

    import uc_pkg::*;

    state_t state_next;
    state_t src_q;                                  // plan of the current instruction
    state_t dst_q;
    state_t exec_q;
    state_t store_q;

    //////////////////// state register
    always_ff @(posedge clk) begin
        if (!rst)
            state <= reset;
        else
            state <= state_next;
    end

    // plan is taken only while decoding
    always_ff @(posedge clk) begin
        if (!rst) begin
            src_q     <= reset;
            dst_q     <= reset;
            exec_q    <= reset;
            store_q   <= reset;
            decoded_d <= 1'b0;
        end else if (state == decode) begin
            src_q     <= src_plan;
            dst_q     <= dst_plan;
            exec_q    <= exec_plan;
            store_q   <= store_plan;
            decoded_d <= d_plan;
        end
    end

    //////////////////// next state
    always_comb begin
        case (state)
            reset:          state_next = fetch;
            fetch:          state_next = fetch_1;
            fetch_1:        state_next = fetch_2;
            fetch_2:        state_next = decode;
            decode:         state_next = entry_state;   // plan not latched yet

            addr_sum:       state_next = addr_sum_1;
            addr_sum_1:     state_next = addr_sum_2;
            addr_sum_2,
            addr_reg:       state_next = src_q;

            load_src_mem:   state_next = load_src_mem_1;
            load_src_mem_1: state_next = load_src_mem_2;
            load_src_reg,
            load_src_mem_2: state_next = dst_q;

            load_dst_mem:   state_next = load_dst_mem_1;
            load_dst_mem_1: state_next = load_dst_mem_2;
            load_dst_reg,
            load_dst_mem_2: state_next = exec_q;

            exec_1op,
            exec_2op:       state_next = store_q;

            store_mem:      state_next = store_mem_1;   // ram write settles
            store_reg,
            store_mem_1:    state_next = inc_cp;
            inc_cp:         state_next = inc_cp_1;
            inc_cp_1:       state_next = fetch;
            default:        state_next = reset;
        endcase
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/uc_pkg.sv
source/instr_decoder.sv
source/uc_sequencer.sv
source/alu_control.sv
source/bus_control.sv
source/uc.sv
verification/uc_tb.sv

/* verification/uc_tb.sv */
`default_nettype none

module uc_tb;

    //////////////////// state codes
    localparam logic [15:0] ST_RESET        = 16'h00;
    localparam logic [15:0] ST_FETCH        = 16'h10;
    localparam logic [15:0] ST_DECODE       = 16'h20;
    localparam logic [15:0] ST_ADDR_SUM     = 16'h30;
    localparam logic [15:0] ST_ADDR_REG     = 16'h34;
    localparam logic [15:0] ST_LOAD_SRC_REG = 16'h40;
    localparam logic [15:0] ST_LOAD_SRC_MEM = 16'h44;
    localparam logic [15:0] ST_LOAD_DST_REG = 16'h50;
    localparam logic [15:0] ST_LOAD_DST_MEM = 16'h54;
    localparam logic [15:0] ST_EXEC_1OP     = 16'h60;
    localparam logic [15:0] ST_EXEC_2OP     = 16'h64;
    localparam logic [15:0] ST_STORE_REG    = 16'h70;
    localparam logic [15:0] ST_STORE_MEM    = 16'h74;
    localparam logic [15:0] ST_INC_CP       = 16'h80;
    localparam logic [15:0] NONE            = 16'hffff;    // empty phase slot

    localparam logic [17:0] FETCH_0 = 18'h01040;            // cp_oe, am_we
    localparam logic [17:0] FETCH_1 = 18'h00080;            // am_oe
    localparam logic [17:0] FETCH_2 = 18'h04001;            // ram_oe, ri_we

    // phases after decode in order
    localparam logic [5:0][15:0] PLAN_REG2 = {NONE, ST_LOAD_SRC_REG, ST_LOAD_DST_REG,
                                              ST_EXEC_2OP, ST_STORE_REG, ST_INC_CP};
    localparam logic [5:0][15:0] PLAN_CMP  = {NONE, ST_LOAD_SRC_REG, ST_LOAD_DST_REG,
                                              ST_EXEC_2OP, NONE, ST_INC_CP};
    localparam logic [5:0][15:0] PLAN_MEM1 = {ST_ADDR_SUM, ST_LOAD_SRC_MEM, ST_LOAD_DST_MEM,
                                              ST_EXEC_1OP, ST_STORE_MEM, ST_INC_CP};
    localparam logic [5:0][15:0] PLAN_MOV  = {ST_ADDR_REG, ST_LOAD_SRC_MEM, ST_LOAD_DST_REG,
                                              ST_EXEC_1OP, ST_STORE_REG, ST_INC_CP};
    localparam logic [5:0][15:0] PLAN_JMPM = {ST_ADDR_REG, NONE, NONE, ST_EXEC_1OP, NONE, NONE};
    localparam logic [5:0][15:0] PLAN_JMPR = {NONE, ST_LOAD_SRC_REG, ST_LOAD_DST_REG,
                                              ST_EXEC_1OP, NONE, NONE};

    localparam int MAX_ROWS     = 20;
    localparam int MAX_LEN      = 18;
    localparam int RESET_CYCLES = 16;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] ri;
    logic [15:0] ind;
    logic [2:0]  regs_addr;
    logic        regs_oe;
    logic        regs_we;
    logic        alu_oe;
    logic        alu_carry;
    logic [3:0]  alu_opcode;
    logic        ram_oe;
    logic        ram_we;
    logic        cp_oe;
    logic        cp_we;
    logic        ind_sel;
    logic        ind_oe;
    logic        ind_we;
    logic        am_oe;
    logic        am_we;
    logic        t1_oe;
    logic        t1_we;
    logic        t2_oe;
    logic        t2_we;
    logic        ri_oe;
    logic        ri_we;
    logic [15:0] disp_state;
    logic [17:0] strobes;

    //////////////////// table
    string       row_name [MAX_ROWS];
    logic [6:0]  row_op   [MAX_ROWS];
    logic        row_d    [MAX_ROWS];
    logic [2:0]  row_rg   [MAX_ROWS];
    logic [2:0]  row_rm   [MAX_ROWS];
    logic [15:0] row_ri   [MAX_ROWS];
    logic [15:0] row_ind  [MAX_ROWS];
    logic [3:0]  row_aop  [MAX_ROWS];                   // alu opcode in exec
    logic        row_ac   [MAX_ROWS];                   // alu carry in exec
    logic [15:0] row_seq  [MAX_ROWS][MAX_LEN];
    int          row_len  [MAX_ROWS];
    int          n_rows;
    int          cycles;
    int          cycle_limit;
    string       cur_name;

    uc uc_i (.*);

    assign strobes = {regs_oe, regs_we, alu_oe, ram_oe, ram_we, cp_oe, cp_we, ind_sel, ind_oe,
                      ind_we, am_oe, am_we, t1_oe, t1_we, t2_oe, t2_we, ri_oe, ri_we};

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ri bit 0 is the opcode msb, so the fields go in reversed
    function automatic logic [15:0] encode(input logic [6:0] op, input logic d,
                                           input logic [1:0] md, input logic [2:0] rg,
                                           input logic [2:0] rm);
        logic [15:0] w;
        w = {<<{op, d, md, rg, rm}};
        return w;
    endfunction

    function automatic int span(input logic [15:0] ph);
        case (ph)
            ST_FETCH, ST_ADDR_SUM, ST_LOAD_SRC_MEM, ST_LOAD_DST_MEM: return 3;
            ST_STORE_MEM, ST_INC_CP: return 2;
            NONE: return 0;
            default: return 1;
        endcase
    endfunction

    task automatic add_row(input string name, input logic [6:0] op, input logic d,
                           input logic [1:0] md, input logic [2:0] rg, input logic [2:0] rm,
                           input logic [15:0] ind_val, input logic [3:0] aop, input logic ac,
                           input logic [5:0][15:0] ph);
        logic [7:0][15:0] phases;
        int               n;
        int               i;
        int               j;
        phases = {ST_FETCH, ST_DECODE, ph};
        n = 0;
        for (i = 7; i >= 0; i--) begin
            for (j = 0; j < span(phases[i]); j++) begin
                row_seq[n_rows][n] = phases[i] + 16'(j);   // base, base+1, base+2
                n++;
            end
        end
        row_name[n_rows] = name;
        row_op[n_rows]   = op;
        row_d[n_rows]    = d;
        row_rg[n_rows]   = rg;
        row_rm[n_rows]   = rm;
        row_ri[n_rows]   = encode(op, d, md, rg, rm);
        row_ind[n_rows]  = ind_val;
        row_aop[n_rows]  = aop;
        row_ac[n_rows]   = ac;
        row_len[n_rows]  = n;
        n_rows++;
    endtask

    // register mode with random rg, rm and flag carry
    task automatic add_reg_row(input string name, input logic [6:0] op, input logic d,
                               input logic [3:0] aop, input logic use_c,
                               input logic [5:0][15:0] ph);
        logic [31:0] rnd;
        logic [2:0]  rg;
        logic [2:0]  rm;
        rnd = $urandom;
        rg  = rnd[2:0];
        rm  = rnd[5:3];
        if (rm == rg)
            rm = ~rg;                                   // store_reg shows which one d picks
        add_row(name, op, d, 2'b11, rg, rm, {15'd0, rnd[6]}, aop, use_c & rnd[6], ph);
    endtask

    task automatic build_table;
        add_reg_row("add", 7'b0101000, 1'b1, 4'd0, 1'b0, PLAN_REG2);
        add_reg_row("adc", 7'b0101001, 1'b0, 4'd0, 1'b1, PLAN_REG2);
        add_reg_row("sub", 7'b0101010, 1'b1, 4'd1, 1'b0, PLAN_REG2);
        add_reg_row("sbb", 7'b0101011, 1'b0, 4'd1, 1'b1, PLAN_REG2);
        add_reg_row("and", 7'b0101100, 1'b1, 4'd4, 1'b0, PLAN_REG2);
        add_reg_row("or",  7'b0101101, 1'b0, 4'd5, 1'b0, PLAN_REG2);
        add_reg_row("xor", 7'b0101110, 1'b1, 4'd6, 1'b0, PLAN_REG2);
        add_reg_row("cmp", 7'b0100010, 1'b1, 4'd1, 1'b0, PLAN_CMP);
        add_reg_row("test", 7'b0100100, 1'b0, 4'd4, 1'b0, PLAN_CMP);
        add_row("inc", 7'b0001000, 1'b0, 2'b00, 3'd2, 3'd0, 16'h0000, 4'd0, 1'b1, PLAN_MEM1);
        add_row("dec", 7'b0001001, 1'b0, 2'b00, 3'd1, 3'd1, 16'hffff, 4'd1, 1'b1, PLAN_MEM1);
        add_row("neg", 7'b0001010, 1'b1, 2'b01, 3'd0, 3'd2, 16'h0001, 4'd2, 1'b0, PLAN_MEM1);
        add_row("not", 7'b0001011, 1'b0, 2'b00, 3'd7, 3'd3, 16'h0000, 4'd3, 1'b0, PLAN_MEM1);
        add_row("shl", 7'b0001100, 1'b0, 2'b00, 3'd3, 3'd1, 16'h0001, 4'd7, 1'b0, PLAN_MEM1);
        add_row("shr", 7'b0001101, 1'b0, 2'b00, 3'd5, 3'd2, 16'h0000, 4'd8, 1'b0, PLAN_MEM1);
        add_row("sar", 7'b0001110, 1'b0, 2'b00, 3'd6, 3'd3, 16'h0000, 4'd9, 1'b0, PLAN_MEM1);
        add_row("mov", 7'b0000000, 1'b1, 2'b00, 3'd3, 3'd5, 16'h0000, 4'd5, 1'b0, PLAN_MOV);
        add_row("jmp mem", 7'b0000101, 1'b0, 2'b00, 3'd1, 3'd6, 16'h0000, 4'd5, 1'b0,
                PLAN_JMPM);
        add_reg_row("jmp reg", 7'b0000101, 1'b0, 4'd5, 1'b0, PLAN_JMPR);
    endtask

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected %0h, actual %0h", cur_name, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_reset;
        check_eq("disp_state", 32'(ST_RESET), 32'(disp_state));
        check_eq("strobes", 0, 32'(strobes));
        check_eq("regs_addr", 0, 32'(regs_addr));
        check_eq("alu_opcode", 0, 32'(alu_opcode));
        check_eq("alu_carry", 0, 32'(alu_carry));
    endtask

    task automatic check_cycle(input int r, input int k);
        logic [15:0] st;
        logic        xfer;
        logic        jmp;
        st   = row_seq[r][k];
        xfer = !row_op[r][5] && !row_op[r][3];              // mov, jmp
        jmp  = xfer && (row_op[r][2:0] == 3'b101);
        check_eq("disp_state", 32'(st), 32'(disp_state));
        check_eq("regs_we", 32'(st == ST_STORE_REG), 32'(regs_we));
        check_eq("ram_we", 32'(st == ST_STORE_MEM), 32'(ram_we));
        check_eq("cp_we", 32'(st == ST_INC_CP + 16'd1 || (st == ST_EXEC_1OP && jmp)),
                 32'(cp_we));
        case (st)
            ST_FETCH:            check_eq("strobes", 32'(FETCH_0), 32'(strobes));
            ST_FETCH + 16'd1:    check_eq("strobes", 32'(FETCH_1), 32'(strobes));
            ST_FETCH + 16'd2:    check_eq("strobes", 32'(FETCH_2), 32'(strobes));
            ST_ADDR_SUM:         check_eq("regs_addr", 32'(row_rm[r][1] ? 3'd7 : 3'd6),
                                          32'(regs_addr));  // bb or ba
            ST_ADDR_SUM + 16'd1: check_eq("regs_addr", 32'(row_rm[r][0] ? 3'd5 : 3'd4),
                                          32'(regs_addr));  // xb or xa
            ST_ADDR_REG:         check_eq("regs_addr", 32'(row_rm[r]), 32'(regs_addr));
            ST_STORE_REG:        check_eq("regs_addr", 32'(row_d[r] ? row_rg[r] : row_rm[r]),
                                          32'(regs_addr));
            ST_EXEC_1OP, ST_EXEC_2OP: begin
                check_eq("alu_opcode", 32'(row_aop[r]), 32'(alu_opcode));
                check_eq("alu_carry", 32'(row_ac[r]), 32'(alu_carry));
                check_eq("ind_we", 32'(!xfer), 32'(ind_we));
                check_eq("ind_sel", 32'(!xfer), 32'(ind_sel));
            end
            ST_INC_CP + 16'd1: begin
                check_eq("alu_opcode", 0, 32'(alu_opcode));  // adc
                check_eq("alu_carry", 1, 32'(alu_carry));
            end
            default: ;
        endcase
    endtask

    //////////////////// main sequence
    initial begin
        int r;
        int k;
        rst      = 1'b0;
        ri       = '0;
        ind      = '0;
        cycles   = 0;
        n_rows   = 0;
        cur_name = "reset";
        void'($urandom(32'hcba4d7be));
        build_table();
        cycle_limit = RESET_CYCLES + 20;
        for (r = 0; r < n_rows; r++)
            cycle_limit += row_len[r];

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset();
        end
        rst = 1'b1;                                     // still in reset until next edge
        ri  = row_ri[0];
        ind = row_ind[0];

        for (r = 0; r < n_rows; r++) begin
            cur_name = row_name[r];
            for (k = 0; k < row_len[r]; k++) begin
                @(negedge clk);
                check_cycle(r, k);
            end
            if (r + 1 < n_rows) begin
                ri  = row_ri[r + 1];                    // next instruction from its fetch
                ind = row_ind[r + 1];
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
